// ==== files.f ====
common/dmac_pkg.sv
verilog/dmac_regs.sv
src_axi_stream/dmac_data_mover.sv
src_axi_stream/dmac_src_axi_stream.sv
verilog/dmac_beat_fifo.sv
verilog/dmac_stream_src_top.sv
test/tb_clock_gen.sv
test/tb_dmac_stream_src.sv

// ==== test/tb_dmac_stream_src.sv ====
// **************************************************
// DMA stream source testbench
// Directed tests over the Wishbone register port,
// the input stream and the output stream
// **************************************************

module tb_dmac_stream_src;

  localparam int total_beats = 36;
  localparam int cycle_limit = total_beats * 4 + 500;

  logic        clk;
  logic        rst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [1:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  logic        s_axis_valid;
  logic        s_axis_ready;
  logic [31:0] s_axis_data;
  logic [0:0]  s_axis_user;
  logic        s_axis_xfer_req;
  logic        m_axis_valid;
  logic        m_axis_ready;
  logic [31:0] m_axis_data;
  logic        m_axis_last;

  integer      seed;
  logic        random_ready;
  int          cycle_count = 0;
  int          pass_count = 0;
  int          fail_count = 0;
  int          test_errors;
  string       test_name;
  logic [31:0] rd;
  logic [dmac_pkg::id_width-1:0] exp_id;
  // Beats seen on the output and the beats the tests expect there
  logic [31:0] out_data[$];
  logic        out_last[$];
  logic [31:0] exp_data[$];
  logic        exp_last[$];

  tb_clock_gen #(.PERIOD(8), .RESET_CYCLES(5)) clock_gen_i (.clk(clk), .rst_n(rst_n));

  dmac_stream_src_top #(
    .DATA_WIDTH (32),
    .FIFO_DEPTH (4)
  ) dmac_stream_src_top_i (
    .s_axis_aclk     (clk),
    .s_axis_aresetn  (rst_n),
    .wb_cyc          (wb_cyc),
    .wb_stb          (wb_stb),
    .wb_we           (wb_we),
    .wb_adr          (wb_adr),
    .wb_dat_w        (wb_dat_w),
    .wb_dat_r        (wb_dat_r),
    .wb_ack          (wb_ack),
    .s_axis_valid    (s_axis_valid),
    .s_axis_ready    (s_axis_ready),
    .s_axis_data     (s_axis_data),
    .s_axis_user     (s_axis_user),
    .s_axis_xfer_req (s_axis_xfer_req),
    .m_axis_valid    (m_axis_valid),
    .m_axis_ready    (m_axis_ready),
    .m_axis_data     (m_axis_data),
    .m_axis_last     (m_axis_last)
  );

  // **************************************************
  // Output side: collector, sink and run limit
  // **************************************************

  // Halfway through the cycle the output handshake is settled for the next edge
  always @(negedge clk) begin
    if (m_axis_valid && m_axis_ready) begin
      out_data.push_back(m_axis_data);
      out_last.push_back(m_axis_last);
    end
  end

  // Sink either always takes beats or stalls at random
  always @(posedge clk) begin
    #1;
    m_axis_ready = random_ready ? $random(seed) : 1'b1;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("Timeout after %0d cycles, a handshake never completed", cycle_count);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // **************************************************
  // Helpers
  // **************************************************

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] %s: %s expected %h actual %h", test_name, what, expected, actual);
      test_errors++;
    end
  endtask

  // Expected STATUS word built from the register map fields
  function automatic logic [31:0] status_word(input logic en, input logic pending,
      input logic active, input logic [2:0] req_id, input logic [2:0] resp_id);
    status_word = '0;
    status_word[0] = en;
    status_word[1] = pending;
    status_word[2] = active;
    status_word[6:4] = req_id;
    status_word[10:8] = resp_id;
  endfunction

  // One classic cycle, held until ack, then one idle cycle on the bus
  task automatic bus_cycle(input logic we, input logic [1:0] adr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    int waited;
    waited = 0;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = adr;
    wb_dat_w = wdata;
    do begin
      @(posedge clk);
      #1;
      waited++;
    end while (!wb_ack);
    rdata = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    check_value("ack latency", 1, waited);
    @(posedge clk);
    #1;
  endtask

  task automatic wb_write(input logic [1:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    bus_cycle(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input logic [1:0] adr, output logic [31:0] data);
    bus_cycle(1'b0, adr, 32'd0, data);
  endtask

  // Ready is settled one unit after the edge, so it tells whether the next edge takes the beat
  task automatic send_beat(input logic [31:0] data, input logic user);
    logic taken;
    s_axis_valid = 1'b1;
    s_axis_data = data;
    s_axis_user = user;
    do begin
      taken = s_axis_ready;
      @(posedge clk);
      #1;
    end while (!taken);
    s_axis_valid = 1'b0;
  endtask

  task automatic send_beats(input logic [31:0] first, input int count, input logic user);
    for (int i = 0; i < count; i++) begin
      send_beat(first + i, user);
    end
  endtask

  task automatic expect_burst(input logic [31:0] first, input int count);
    for (int i = 0; i < count; i++) begin
      exp_data.push_back(first + i);
      exp_last.push_back(i == count - 1);
    end
  endtask

  // A few spare cycles after the last beat would expose duplicates
  task automatic wait_for_beats(input int expected);
    int waited;
    waited = 0;
    while (out_data.size() < expected && waited < 200) begin
      @(posedge clk);
      #1;
      waited++;
    end
    repeat (4) @(posedge clk);
    #1;
  endtask

  task automatic compare_output;
    for (int i = 0; i < exp_data.size() && i < out_data.size(); i++) begin
      check_value($sformatf("beat %0d data", i), exp_data[i], out_data[i]);
      check_value($sformatf("beat %0d last", i), exp_last[i], out_last[i]);
    end
    check_value("output beat count", exp_data.size(), out_data.size());
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errors = 0;
    out_data.delete();
    out_last.delete();
    exp_data.delete();
    exp_last.delete();
  endtask

  task automatic finish_test;
    if (test_errors == 0) begin
      pass_count++;
      $display("[PASS] %s", test_name);
    end else begin
      fail_count++;
      $display("[DONE] %s finished with %0d errors", test_name, test_errors);
    end
  endtask

  // **************************************************
  // Tests
  // **************************************************

  task automatic test_reset_and_registers;
    start_test("reset_and_registers");
    check_value("s_axis_ready after reset", 0, s_axis_ready);
    check_value("m_axis_valid after reset", 0, m_axis_valid);
    check_value("xfer_req after reset", 0, s_axis_xfer_req);
    wb_read(dmac_pkg::addr_status, rd);
    check_value("status after reset", 0, rd);
    wb_write(dmac_pkg::addr_control, 32'd1);
    wb_read(dmac_pkg::addr_control, rd);
    check_value("control readback", 1, rd);
    wb_write(dmac_pkg::addr_control, 32'd0);
    wb_read(dmac_pkg::addr_control, rd);
    check_value("control cleared", 0, rd);
    wb_write(dmac_pkg::addr_control, 32'd1);
    wb_read(dmac_pkg::addr_status, rd);
    check_value("status enabled", status_word(1, 0, 0, 0, 0), rd);
    wb_read(dmac_pkg::addr_request, rd);
    check_value("request reads zero", 0, rd);
    finish_test();
  endtask

  // The burst is taken during the idle bus cycle, so it runs before any beat arrives
  task automatic test_single_burst;
    start_test("single_burst");
    wb_write(dmac_pkg::addr_request, 32'd5);
    exp_id++;
    check_value("xfer_req during burst", 1, s_axis_xfer_req);
    wb_read(dmac_pkg::addr_status, rd);
    check_value("status during burst", status_word(1, 0, 1, exp_id, exp_id - 1'b1), rd);
    send_beats(32'h1000, 6, 1'b0);
    expect_burst(32'h1000, 6);
    wait_for_beats(6);
    compare_output();
    wb_read(dmac_pkg::addr_status, rd);
    check_value("status after burst", status_word(1, 0, 0, exp_id, exp_id), rd);
    finish_test();
  endtask

  // Three beats go before sync, then the user pattern mixes high and low
  task automatic test_sync_start;
    logic [4:0] user_pattern;
    user_pattern = 5'b00101;
    start_test("sync_start");
    wb_write(dmac_pkg::addr_request, 32'h14);
    exp_id++;
    send_beats(32'h2000, 3, 1'b0);
    for (int i = 0; i < 5; i++) begin
      send_beat(32'h2003 + i, user_pattern[i]);
    end
    expect_burst(32'h2003, 5);
    wait_for_beats(5);
    compare_output();
    wb_read(dmac_pkg::addr_status, rd);
    check_value("status after sync burst", status_word(1, 0, 0, exp_id, exp_id), rd);
    finish_test();
  endtask

  task automatic test_back_pressure;
    logic [31:0] data;
    start_test("back_pressure");
    random_ready <= 1'b1;
    wb_write(dmac_pkg::addr_request, 32'd6);
    exp_id++;
    for (int i = 0; i < 7; i++) begin
      data = $random(seed);
      exp_data.push_back(data);
      exp_last.push_back(i == 6);
      send_beat(data, 1'b0);
    end
    wb_write(dmac_pkg::addr_request, 32'd9);
    exp_id++;
    for (int i = 0; i < 10; i++) begin
      data = $random(seed);
      exp_data.push_back(data);
      exp_last.push_back(i == 9);
      send_beat(data, 1'b0);
    end
    wait_for_beats(17);
    random_ready <= 1'b0;
    compare_output();
    wb_read(dmac_pkg::addr_status, rd);
    check_value("status after two bursts", status_word(1, 0, 0, exp_id, exp_id), rd);
    finish_test();
  endtask

  task automatic test_disable;
    start_test("disable");
    wb_write(dmac_pkg::addr_control, 32'd0);
    wb_write(dmac_pkg::addr_request, 32'd2);
    repeat (8) begin
      check_value("s_axis_ready while disabled", 0, s_axis_ready);
      @(posedge clk);
      #1;
    end
    wb_read(dmac_pkg::addr_status, rd);
    check_value("status while disabled", status_word(0, 1, 0, exp_id, exp_id), rd);
    wb_write(dmac_pkg::addr_control, 32'd1);
    exp_id++;
    send_beats(32'h3000, 3, 1'b0);
    expect_burst(32'h3000, 3);
    wait_for_beats(3);
    compare_output();
    wb_read(dmac_pkg::addr_status, rd);
    check_value("status after enable", status_word(1, 0, 0, exp_id, exp_id), rd);
    finish_test();
  endtask

  // The second write carries a longer burst, which must not replace the first
  task automatic test_double_request;
    start_test("double_request");
    wb_write(dmac_pkg::addr_control, 32'd0);
    wb_write(dmac_pkg::addr_request, 32'd1);
    wb_write(dmac_pkg::addr_request, 32'd5);
    wb_read(dmac_pkg::addr_status, rd);
    check_value("status with one pending", status_word(0, 1, 0, exp_id, exp_id), rd);
    wb_write(dmac_pkg::addr_control, 32'd1);
    exp_id++;
    send_beats(32'h4000, 2, 1'b0);
    expect_burst(32'h4000, 2);
    wait_for_beats(2);
    compare_output();
    wb_read(dmac_pkg::addr_status, rd);
    check_value("request id advanced once", status_word(1, 0, 0, exp_id, exp_id), rd);
    finish_test();
  endtask

  initial begin
    seed = 32'h40b6_b311;
    exp_id = '0;
    random_ready = 1'b0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = 2'd0;
    wb_dat_w = 32'd0;
    s_axis_valid = 1'b0;
    s_axis_data = 32'd0;
    s_axis_user = 1'b0;
    m_axis_ready = 1'b1;
    @(posedge rst_n);
    @(posedge clk);
    #1;
    test_reset_and_registers();
    test_single_burst();
    test_sync_start();
    test_back_pressure();
    test_disable();
    test_double_request();
    $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== test/tb_clock_gen.sv ====
// **************************************************
// Testbench clock and reset
// Free running clock and an active low reset
// **************************************************

module tb_clock_gen #(
  parameter int PERIOD       = 8,
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Reset lets go just after a rising edge, like the other stimulus
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

// ==== verilog/dmac_stream_src_top.sv ====
// **************************************************
// DMA stream source top level
// Register block, stream source and output FIFO
// **************************************************

module dmac_stream_src_top #(
  parameter int DATA_WIDTH = 32,
  parameter int FIFO_DEPTH = 4
) (
  input  logic                  s_axis_aclk,
  input  logic                  s_axis_aresetn,

  // Wishbone classic register port
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  logic [1:0]            wb_adr,
  input  logic [31:0]           wb_dat_w,
  output logic [31:0]           wb_dat_r,
  output logic                  wb_ack,

  // AXI4-Stream input
  input  logic                  s_axis_valid,
  output logic                  s_axis_ready,
  input  logic [DATA_WIDTH-1:0] s_axis_data,
  input  logic [0:0]            s_axis_user,
  output logic                  s_axis_xfer_req,

  // AXI4-Stream output
  output logic                  m_axis_valid,
  input  logic                  m_axis_ready,
  output logic [DATA_WIDTH-1:0] m_axis_data,
  output logic                  m_axis_last
);

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  last;
  } dmac_beat_t;

  dmac_pkg::dmac_req_t           req;
  logic                          req_valid;
  logic                          req_ready;
  logic                          enable;
  logic                          enabled;
  logic [dmac_pkg::id_width-1:0] request_id;
  logic [dmac_pkg::id_width-1:0] response_id;
  dmac_beat_t                    beat;
  logic                          beat_valid;
  logic                          beat_ready;

  dmac_regs dmac_regs_i (
    .s_axis_aclk    (s_axis_aclk),
    .s_axis_aresetn (s_axis_aresetn),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_we          (wb_we),
    .wb_adr         (wb_adr),
    .wb_dat_w       (wb_dat_w),
    .wb_dat_r       (wb_dat_r),
    .wb_ack         (wb_ack),
    .enable         (enable),
    .req            (req),
    .req_valid      (req_valid),
    .req_ready      (req_ready),
    .enabled        (enabled),
    .request_id     (request_id),
    .response_id    (response_id),
    .xfer_req       (s_axis_xfer_req)
  );

  dmac_src_axi_stream #(
    .DATA_WIDTH (DATA_WIDTH)
  ) dmac_src_axi_stream_i (
    .s_axis_aclk     (s_axis_aclk),
    .s_axis_aresetn  (s_axis_aresetn),
    .enable          (enable),
    .enabled         (enabled),
    .req             (req),
    .req_valid       (req_valid),
    .req_ready       (req_ready),
    .request_id      (request_id),
    .response_id     (response_id),
    .s_axis_valid    (s_axis_valid),
    .s_axis_ready    (s_axis_ready),
    .s_axis_data     (s_axis_data),
    .s_axis_user     (s_axis_user),
    .s_axis_xfer_req (s_axis_xfer_req),
    .beat            (beat),
    .beat_valid      (beat_valid),
    .beat_ready      (beat_ready)
  );

  // Input back-pressure follows the FIFO fill level
  dmac_beat_fifo #(
    .DATA_WIDTH (DATA_WIDTH),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) dmac_beat_fifo_i (
    .s_axis_aclk    (s_axis_aclk),
    .s_axis_aresetn (s_axis_aresetn),
    .wr_beat        (beat),
    .wr_valid       (beat_valid),
    .wr_ready       (beat_ready),
    .m_axis_valid   (m_axis_valid),
    .m_axis_ready   (m_axis_ready),
    .m_axis_data    (m_axis_data),
    .m_axis_last    (m_axis_last)
  );

endmodule

// ==== verilog/dmac_beat_fifo.sv ====
// **************************************************
// DMA output beat FIFO
// Circular buffer between the stream source and the
// master stream port that absorbs back-pressure
// **************************************************

module dmac_beat_fifo #(
  parameter int DATA_WIDTH = 32,
  parameter int FIFO_DEPTH = 4
) (
  s_axis_aclk, s_axis_aresetn,
  wr_beat, wr_valid, wr_ready,
  m_axis_valid, m_axis_ready, m_axis_data, m_axis_last
);

  // Stored entry, data together with its last flag
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  last;
  } dmac_beat_t;

  localparam int ptr_width   = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int count_width = $clog2(FIFO_DEPTH + 1);

  input  logic                  s_axis_aclk;
  input  logic                  s_axis_aresetn;

  input  dmac_beat_t            wr_beat;
  input  logic                  wr_valid;
  output logic                  wr_ready;

  output logic                  m_axis_valid;
  input  logic                  m_axis_ready;
  output logic [DATA_WIDTH-1:0] m_axis_data;
  output logic                  m_axis_last;

  dmac_beat_t             mem [FIFO_DEPTH];
  logic [ptr_width-1:0]   wr_ptr;
  logic [ptr_width-1:0]   rd_ptr;
  logic [count_width-1:0] count;
  logic                   push;
  logic                   pop;

  // Full and empty both come straight from the occupancy count
  assign wr_ready     = count != count_width'(FIFO_DEPTH);
  assign m_axis_valid = count != '0;
  assign push         = wr_valid & wr_ready;
  assign pop          = m_axis_valid & m_axis_ready;

  // The head entry is always on the output
  assign m_axis_data = mem[rd_ptr].data;
  assign m_axis_last = mem[rd_ptr].last;

  // Pointers wrap by hand so any depth works
  always_ff @(posedge s_axis_aclk) begin
    if (!s_axis_aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_width'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_width'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave the count as it is
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge s_axis_aclk) begin
    if (push) begin
      mem[wr_ptr] <= wr_beat;
    end
  end

endmodule

// ==== src_axi_stream/dmac_src_axi_stream.sv ====
// **************************************************
// AXI4-Stream DMA source
// Drops input beats until sync when a request asks
// for it and feeds the rest through the data mover
// **************************************************

module dmac_src_axi_stream #(
  parameter int DATA_WIDTH = 32
) (
  s_axis_aclk, s_axis_aresetn,
  enable, enabled,
  req, req_valid, req_ready,
  request_id, response_id,
  s_axis_valid, s_axis_ready, s_axis_data, s_axis_user, s_axis_xfer_req,
  beat, beat_valid, beat_ready
);

  // Beat as it is handed on to the output FIFO
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  last;
  } dmac_beat_t;

  input  logic                          s_axis_aclk;
  input  logic                          s_axis_aresetn;

  input  logic                          enable;
  output logic                          enabled;

  input  dmac_pkg::dmac_req_t           req;
  input  logic                          req_valid;
  output logic                          req_ready;
  output logic [dmac_pkg::id_width-1:0] request_id;
  output logic [dmac_pkg::id_width-1:0] response_id;

  input  logic                          s_axis_valid;
  output logic                          s_axis_ready;
  input  logic [DATA_WIDTH-1:0]         s_axis_data;
  input  logic [0:0]                    s_axis_user;
  output logic                          s_axis_xfer_req;

  output dmac_beat_t                    beat;
  output logic                          beat_valid;
  input  logic                          beat_ready;

  logic                  needs_sync;
  logic                  discard;
  logic [DATA_WIDTH-1:0] mover_data;
  logic                  mover_last;

  // While waiting for sync every beat without tuser[0] is thrown away
  assign discard = needs_sync & ~s_axis_user[0];

  // The sync flag follows the accepted request and clears on the sync beat
  always_ff @(posedge s_axis_aclk) begin
    if (!s_axis_aresetn) begin
      needs_sync <= 1'b0;
    end else if (s_axis_valid && s_axis_ready && s_axis_user[0]) begin
      needs_sync <= 1'b0;
    end else if (req_valid && req_ready) begin
      needs_sync <= req.sync_transfer_start;
    end
  end

  dmac_data_mover #(
    .DATA_WIDTH (DATA_WIDTH)
  ) data_mover_i (
    .s_axis_aclk           (s_axis_aclk),
    .s_axis_aresetn        (s_axis_aresetn),
    .enable                (enable),
    .enabled               (enabled),
    .req_valid             (req_valid),
    .req_ready             (req_ready),
    .req_last_burst_length (req.last_burst_length),
    .request_id            (request_id),
    .response_id           (response_id),
    .xfer_req              (s_axis_xfer_req),
    .in_valid              (s_axis_valid),
    .in_ready              (s_axis_ready),
    .in_discard            (discard),
    .in_data               (s_axis_data),
    .out_valid             (beat_valid),
    .out_ready             (beat_ready),
    .out_data              (mover_data),
    .out_last              (mover_last)
  );

  assign beat = '{data: mover_data, last: mover_last};

endmodule

// ==== src_axi_stream/dmac_data_mover.sv ====
// **************************************************
// DMA data mover
// Runs one burst at a time, counts the forwarded
// beats, flags the last one and tracks the IDs
// **************************************************

module dmac_data_mover #(
  parameter int DATA_WIDTH = 32
) (
  input  logic                                       s_axis_aclk,
  input  logic                                       s_axis_aresetn,

  input  logic                                       enable,
  output logic                                       enabled,

  // Burst requests
  input  logic                                       req_valid,
  output logic                                       req_ready,
  input  logic [dmac_pkg::beats_per_burst_width-1:0] req_last_burst_length,

  output logic [dmac_pkg::id_width-1:0]              request_id,
  output logic [dmac_pkg::id_width-1:0]              response_id,
  output logic                                       xfer_req,

  // Input beats, discarded ones are consumed without being forwarded
  input  logic                                       in_valid,
  output logic                                       in_ready,
  input  logic                                       in_discard,
  input  logic [DATA_WIDTH-1:0]                      in_data,

  // Forwarded beats
  output logic                                       out_valid,
  input  logic                                       out_ready,
  output logic [DATA_WIDTH-1:0]                      out_data,
  output logic                                       out_last
);

  localparam int len_width = dmac_pkg::beats_per_burst_width;

  logic                 active;
  logic [len_width-1:0] beat_counter;
  logic [len_width-1:0] last_burst_length;
  logic                 req_accept;
  logic                 beat_accept;
  logic                 beat_forward;
  logic                 last_beat;

  // **************************************************
  // Handshakes
  // **************************************************

  // New bursts are only taken while idle and with enable still set
  assign req_ready  = enable & enabled & ~active;
  assign req_accept = req_valid & req_ready;

  // Input is consumed only while a burst runs and the output has room
  assign in_ready    = active & out_ready;
  assign beat_accept = in_valid & in_ready;

  // A discarded beat leaves the input but never reaches the output
  assign beat_forward = beat_accept & ~in_discard;
  assign out_valid    = active & in_valid & ~in_discard;
  assign out_data     = in_data;

  // The counter holds the index of the beat now on the output
  assign last_beat = beat_counter == last_burst_length;
  assign out_last  = last_beat;

  assign xfer_req = active;

  // **************************************************
  // Burst state
  // **************************************************

  always_ff @(posedge s_axis_aclk) begin
    if (!s_axis_aresetn) begin
      active       <= 1'b0;
      enabled      <= 1'b0;
      beat_counter <= '0;
      request_id   <= '0;
      response_id  <= '0;
    end else begin
      // Enable changes only take effect between bursts
      if (!active) begin
        enabled <= enable;
      end

      if (req_accept) begin
        active       <= 1'b1;
        beat_counter <= '0;
        request_id   <= request_id + 1'b1;
      end else if (beat_forward) begin
        if (last_beat) begin
          // The burst ends on the edge that moves its final beat
          active       <= 1'b0;
          beat_counter <= '0;
          response_id  <= response_id + 1'b1;
        end else begin
          beat_counter <= beat_counter + 1'b1;
        end
      end
    end
  end

  // Length of the running burst, captured with the request
  always_ff @(posedge s_axis_aclk) begin
    if (req_accept) begin
      last_burst_length <= req_last_burst_length;
    end
  end

endmodule

// ==== verilog/dmac_regs.sv ====
// **************************************************
// DMA register block
// Wishbone classic slave that holds the enable bit,
// queues one burst request and reports the IDs
// **************************************************

module dmac_regs (
  input  logic                              s_axis_aclk,
  input  logic                              s_axis_aresetn,

  // Wishbone classic slave port
  input  logic                              wb_cyc,
  input  logic                              wb_stb,
  input  logic                              wb_we,
  input  logic [1:0]                        wb_adr,
  input  logic [31:0]                       wb_dat_w,
  output logic [31:0]                       wb_dat_r,
  output logic                              wb_ack,

  // Request interface towards the stream source
  output logic                              enable,
  output dmac_pkg::dmac_req_t               req,
  output logic                              req_valid,
  input  logic                              req_ready,

  // State returned by the stream source
  input  logic                              enabled,
  input  logic [dmac_pkg::id_width-1:0]     request_id,
  input  logic [dmac_pkg::id_width-1:0]     response_id,
  input  logic                              xfer_req
);

  logic        wb_access;
  logic        wb_write;
  logic        req_write;
  logic [31:0] status;
  logic [31:0] read_data;

  // A cycle is served once, on the first clock where cyc and stb are seen
  // The master holds both until ack, so ack blocks a second hit
  assign wb_access = wb_cyc & wb_stb & ~wb_ack;
  assign wb_write  = wb_access & wb_we;
  assign req_write = wb_write & (wb_adr == dmac_pkg::addr_request);

  // Status word assembled from the returned mover state
  always_comb begin
    status = '0;
    status[0] = enabled;
    status[1] = req_valid;
    status[2] = xfer_req;
    status[4 +: dmac_pkg::id_width] = request_id;
    status[8 +: dmac_pkg::id_width] = response_id;
  end

  // Read multiplexer, REQUEST is write only and reads as zero
  always_comb begin
    case (wb_adr)
      dmac_pkg::addr_control: read_data = {31'd0, enable};
      dmac_pkg::addr_status:  read_data = status;
      default:                read_data = '0;
    endcase
  end

  // **************************************************
  // Control state
  // **************************************************

  always_ff @(posedge s_axis_aclk) begin
    if (!s_axis_aresetn) begin
      wb_ack    <= 1'b0;
      enable    <= 1'b0;
      req_valid <= 1'b0;
    end else begin
      // Ack goes high for exactly one cycle per access
      wb_ack <= wb_access;

      if (wb_write && wb_adr == dmac_pkg::addr_control) begin
        enable <= wb_dat_w[0];
      end

      // The pending flag drops when the mover takes the request
      // A write that lands while a request is pending is acked and lost
      if (req_valid && req_ready) begin
        req_valid <= 1'b0;
      end else if (req_write) begin
        req_valid <= 1'b1;
      end
    end
  end

  // Request payload only loads into a free slot
  always_ff @(posedge s_axis_aclk) begin
    if (req_write && !req_valid) begin
      req.last_burst_length   <= wb_dat_w[3:0];
      req.sync_transfer_start <= wb_dat_w[4];
    end
  end

  // Read data is sampled together with the rising ack
  always_ff @(posedge s_axis_aclk) begin
    if (wb_access) begin
      wb_dat_r <= read_data;
    end
  end

endmodule

// ==== common/dmac_pkg.sv ====
// **************************************************
// DMA stream source shared definitions
// Holds the ID and burst length widths, the
// Wishbone register map and the burst request type
// **************************************************

package dmac_pkg;

  // **************************************************
  // Field widths
  // **************************************************

  // Request and response IDs wrap around at this width
  parameter int id_width = 3;

  // A length field of L describes a burst of L+1 beats
  parameter int beats_per_burst_width = 4;

  // **************************************************
  // Wishbone register map
  // **************************************************

  // Word addresses of the three registers
  parameter logic [1:0] addr_control = 2'd0;
  parameter logic [1:0] addr_request = 2'd1;
  parameter logic [1:0] addr_status  = 2'd2;

  // **************************************************
  // Burst request
  // **************************************************

  // One queued burst as it goes from the register block to the mover
  typedef struct packed {
    // Index of the final beat in the burst
    logic [beats_per_burst_width-1:0] last_burst_length;
    // Drop input beats until one arrives with tuser[0] set
    logic                             sync_transfer_start;
  } dmac_req_t;

endpackage
